//--- Bender.yml
package:
  name: tx_buffer

sources:
  - include_dirs:
      - .
    files:
      - axi_lite_pkg.sv
      - tx_buf_pkg.sv
      - mmr_regs.sv
      - sym_fifo.sv
      - tx_ctrl.sv
      - tx_buffer.sv

  - target: test
    include_dirs:
      - .
    files:
      - tb_tx_buffer.sv

//--- axi_lite_pkg.sv
`include "tx_buf_macros.svh"

package axi_lite_pkg;

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_exokay = 2'b01,
        resp_slverr = 2'b10,
        resp_decerr = 2'b11
    } axi_resp_e;

    // master to slave
    typedef struct packed {
        logic                   awvalid;
        logic [`MMR_ADDR_W-1:0] awaddr;
        logic                   wvalid;
        logic [`MMR_DATA_W-1:0] wdata;
        logic                   bready;
        logic                   arvalid;
        logic [`MMR_ADDR_W-1:0] araddr;
        logic                   rready;
    } axi_lite_req_t;

    // slave to master
    typedef struct packed {
        logic                   awready;
        logic                   wready;
        logic                   bvalid;
        axi_resp_e              bresp;
        logic                   arready;
        logic                   rvalid;
        logic [`MMR_DATA_W-1:0] rdata;
        axi_resp_e              rresp;
    } axi_lite_rsp_t;

endpackage

//--- mmr_regs.sv
`include "tx_buf_macros.svh"

module mmr_regs (
    input  logic                        app_clk,
    input  logic                        aresetn,
    input  axi_lite_pkg::axi_lite_req_t axi_req,
    output axi_lite_pkg::axi_lite_rsp_t axi_rsp,
    input  logic                        idle,
    input  logic                        full,
    input  logic                        empty,
    output logic                        start,
    output logic                        wr_en,
    output tx_buf_pkg::symbol_t         wr_sym
);
    import axi_lite_pkg::*;
    import tx_buf_pkg::*;

    typedef logic [`MMR_DATA_W-1:0] data_t;

    logic       arready_q;
    logic       rvalid_q;
    logic       rd_pend;     // address taken, response not yet done
    tx_reg_e    rd_addr;
    data_t      rdata_q;
    data_t      rd_value;

    logic       awready_q;
    logic       wready_q;
    logic       bvalid_q;
    logic       aw_held;
    logic       w_held;
    tx_reg_e    wr_addr;
    data_word_u wr_word;
    logic       commit;      // write response accepted

    sr_t        sr;
    cr_t        cr;
    cr_t        cr_wr;       // control bits carried by the write

    assign sr     = '{ready: idle, full: full, empty: empty};
    assign cr_wr  = cr_t'(wr_word.raw[$bits(cr_t)-1:0]);
    assign commit = bvalid_q && axi_req.bready;
    assign start  = cr.start;

    always_comb begin
        case (rd_addr)
            reg_sr:  rd_value = data_t'(sr);
            reg_cr:  rd_value = data_t'(cr);
            default: rd_value = '0;  // write-only and unmapped read as zero
        endcase
    end

    always_ff @(posedge app_clk) begin
        if (!aresetn) begin
            arready_q <= 1'b0;
            rvalid_q  <= 1'b0;
            rd_pend   <= 1'b0;
        end else begin
            arready_q <= 1'b0;
            if (axi_req.arvalid && !rd_pend) begin
                arready_q <= 1'b1;
                rd_pend   <= 1'b1;
            end
            if (rd_pend && !rvalid_q) begin
                rvalid_q <= 1'b1;
            end else if (rvalid_q && axi_req.rready) begin
                rvalid_q <= 1'b0;
                rd_pend  <= 1'b0;
            end
        end
    end

    always_ff @(posedge app_clk) begin
        if (!aresetn) begin
            awready_q <= 1'b0;
            wready_q  <= 1'b0;
            bvalid_q  <= 1'b0;
            aw_held   <= 1'b0;
            w_held    <= 1'b0;
            wr_en     <= 1'b0;
            cr        <= '0;
        end else begin
            awready_q <= 1'b0;
            wready_q  <= 1'b0;
            wr_en     <= 1'b0;
            if (axi_req.awvalid && !aw_held) begin
                awready_q <= 1'b1;
                aw_held   <= 1'b1;
            end
            if (axi_req.wvalid && !w_held) begin
                wready_q <= 1'b1;
                w_held   <= 1'b1;
            end
            if (aw_held && w_held && !bvalid_q) begin
                bvalid_q <= 1'b1;
            end
            if (cr.start && !idle) begin
                cr.start <= 1'b0;  // transmission under way
            end
            if (commit) begin
                bvalid_q <= 1'b0;
                aw_held  <= 1'b0;
                w_held   <= 1'b0;
                case (wr_addr)
                    reg_cr:   cr    <= cr_wr;
                    reg_cr_s: cr    <= cr | cr_wr;
                    reg_cr_c: cr    <= cr & ~cr_wr;
                    reg_data: wr_en <= 1'b1;
                    default:  ;
                endcase
            end
        end
    end

    // addresses and data words
    always_ff @(posedge app_clk) begin
        if (axi_req.arvalid && !rd_pend) rd_addr <= tx_reg_e'(axi_req.araddr);
        if (rd_pend && !rvalid_q) rdata_q <= rd_value;
        if (axi_req.awvalid && !aw_held) wr_addr <= tx_reg_e'(axi_req.awaddr);
        if (axi_req.wvalid && !w_held) wr_word.raw <= axi_req.wdata;
        if (commit && wr_addr == reg_data) wr_sym <= wr_word.fields.sym;
    end

    assign axi_rsp.awready = awready_q;
    assign axi_rsp.wready  = wready_q;
    assign axi_rsp.bvalid  = bvalid_q;
    assign axi_rsp.bresp   = resp_okay;
    assign axi_rsp.arready = arready_q;
    assign axi_rsp.rvalid  = rvalid_q;
    assign axi_rsp.rdata   = rdata_q;
    assign axi_rsp.rresp   = resp_okay;

    a_bvalid_hold: assert property (@(posedge app_clk) disable iff (!aresetn)
        axi_rsp.bvalid && !axi_req.bready |=> axi_rsp.bvalid);

    a_rvalid_hold: assert property (@(posedge app_clk) disable iff (!aresetn)
        axi_rsp.rvalid && !axi_req.rready |=> axi_rsp.rvalid);

endmodule

//--- sym_fifo.sv
`include "tx_buf_macros.svh"

module sym_fifo (
    input  logic                app_clk,
    input  logic                aresetn,
    input  logic                wr_en,
    input  tx_buf_pkg::symbol_t wr_sym,
    input  logic                rd_en,
    output tx_buf_pkg::symbol_t rd_sym,
    output logic                full,
    output logic                empty
);
    import tx_buf_pkg::*;

    localparam int depth = `TX_FIFO_DEPTH;
    localparam int ptr_w = $clog2(depth);
    localparam int cnt_w = $clog2(depth + 1);

    symbol_t          mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_wr;
    logic             do_rd;

    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] ptr);
        ptr_inc = (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign do_wr = wr_en && !full;  // drop on full
    assign do_rd = rd_en && !empty;
    assign full  = count == cnt_w'(depth);
    assign empty = count == '0;

    always_ff @(posedge app_clk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= ptr_inc(wr_ptr);
            if (do_rd) rd_ptr <= ptr_inc(rd_ptr);
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;  // both or neither
            endcase
        end
    end

    always_ff @(posedge app_clk) begin
        if (do_wr) mem[wr_ptr] <= wr_sym;
        if (do_rd) rd_sym <= mem[rd_ptr];  // valid the cycle after rd_en
    end

    // the sequencer only reads what is queued
    a_no_underflow: assert property (@(posedge app_clk) disable iff (!aresetn)
        rd_en |-> !empty);

endmodule

//--- tb.f
+incdir+.
axi_lite_pkg.sv
tx_buf_pkg.sv
mmr_regs.sv
sym_fifo.sv
tx_ctrl.sv
tx_buffer.sv
tb_tx_buffer.sv

//--- tb_tx_buffer.sv
`include "tx_buf_macros.svh"

module tb_tx_buffer;
    timeunit 1ns;
    timeprecision 100ps;

    import axi_lite_pkg::*;
    import tx_buf_pkg::*;

    localparam int          bus_timeout  = 50;   // cycles per handshake wait
    localparam int          lane_timeout = 200;  // cycles for a whole burst
    localparam logic [31:0] lcg_seed     = 32'd69;

    logic          app_clk;
    logic          aresetn;
    axi_lite_req_t axi_req;
    axi_lite_rsp_t axi_rsp;
    logic          tx_odd;
    logic [7:0]    tx_data;
    logic          tx_charisk;

    symbol_t       lane_q[$];   // symbols seen on the lane
    symbol_t       model_q[$];  // symbols expected in write order
    logic [31:0]   lcg_state;

    tx_buffer dut (
        .app_clk    (app_clk),
        .aresetn    (aresetn),
        .axi_req    (axi_req),
        .axi_rsp    (axi_rsp),
        .tx_odd     (tx_odd),
        .tx_data    (tx_data),
        .tx_charisk (tx_charisk)
    );

    initial begin
        app_clk = 1'b0;
        forever #2 app_clk = ~app_clk;
    end

    // lane phase flips every cycle
    always @(posedge app_clk) begin
        #1;
        tx_odd = ~tx_odd;
    end

    // mid-cycle lane sample where a zero means no symbol
    always @(negedge app_clk) begin
        if (aresetn && (tx_data != 8'h00 || tx_charisk)) begin
            lane_q.push_back(symbol_t'{charisk: tx_charisk, data: tx_data});
        end
    end

    task automatic stop_run();
        $display("Regression failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic report_timeout(input string what);
        $display("ERROR at %0t ns: timed out waiting for %s", $time, what);
        stop_run();
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic symbol_t random_symbol();
        logic [31:0] r;
        symbol_t     s;
        r = lcg_next();
        s.charisk = r[24];
        s.data = r[23:16];
        if (s.data == 8'h00) s.data = 8'h5A;  // zero byte would be invisible on the lane
        return s;
    endfunction

    // SR bits ready, full and empty from bit 2 down
    function automatic logic [31:0] sr_word(input logic ready, input logic full, input logic empty);
        return {29'd0, ready, full, empty};
    endfunction

    task automatic bus_write(input logic [`MMR_ADDR_W-1:0] addr,
                             input logic [`MMR_DATA_W-1:0] data);
        int   cycles;
        logic aw_done;
        logic w_done;
        @(posedge app_clk);
        #1;
        axi_req.awvalid = 1'b1;
        axi_req.awaddr  = addr;
        axi_req.wvalid  = 1'b1;
        axi_req.wdata   = data;
        axi_req.bready  = 1'b1;
        aw_done = 1'b0;
        w_done  = 1'b0;
        cycles  = 0;
        while (!(aw_done && w_done)) begin
            @(negedge app_clk);
            if (axi_rsp.awready) aw_done = 1'b1;
            if (axi_rsp.wready) w_done = 1'b1;
            cycles++;
            if (cycles > bus_timeout) report_timeout("write address or data ready");
            @(posedge app_clk);
            #1;
            if (aw_done) axi_req.awvalid = 1'b0;
            if (w_done) axi_req.wvalid = 1'b0;
        end
        cycles = 0;
        do begin
            @(negedge app_clk);
            cycles++;
            if (cycles > bus_timeout) report_timeout("write response valid");
        end while (!axi_rsp.bvalid);
        check_eq(32'(axi_rsp.bresp), 32'(resp_okay), "write response code");
        @(posedge app_clk);  // commit edge
        #1;
        axi_req.bready = 1'b0;
    endtask

    task automatic bus_read(input logic [`MMR_ADDR_W-1:0] addr,
                            output logic [`MMR_DATA_W-1:0] data);
        int cycles;
        @(posedge app_clk);
        #1;
        axi_req.arvalid = 1'b1;
        axi_req.araddr  = addr;
        axi_req.rready  = 1'b1;
        cycles = 0;
        do begin
            @(negedge app_clk);
            cycles++;
            if (cycles > bus_timeout) report_timeout("read address ready");
        end while (!axi_rsp.arready);
        @(posedge app_clk);
        #1;
        axi_req.arvalid = 1'b0;
        cycles = 0;
        while (!axi_rsp.rvalid) begin
            @(negedge app_clk);
            cycles++;
            if (cycles > bus_timeout) report_timeout("read data valid");
        end
        data = axi_rsp.rdata;
        check_eq(32'(axi_rsp.rresp), 32'(resp_okay), "read response code");
        @(posedge app_clk);
        #1;
        axi_req.rready = 1'b0;
    endtask

    task automatic push_symbol(input symbol_t sym);
        data_word_u w;
        w.raw = '0;
        w.fields.sym = sym;
        bus_write(reg_data, w.raw);
        model_q.push_back(sym);
    endtask

    // wait for the queued burst and compare it in order
    task automatic expect_lane(input string what);
        int          cycles;
        logic [31:0] rd;
        cycles = 0;
        while (lane_q.size() < model_q.size()) begin
            @(posedge app_clk);
            cycles++;
            if (cycles > lane_timeout) report_timeout({what, " symbols on the lane"});
        end
        bus_read(reg_sr, rd);
        check_eq(rd, sr_word(1'b1, 1'b0, 1'b1), {what, ": SR after burst"});
        check_eq(lane_q.size(), model_q.size(), {what, ": lane symbol count"});
        foreach (model_q[i]) begin
            check_eq(32'(lane_q[i]), 32'(model_q[i]), $sformatf("%s: symbol %0d", what, i));
        end
        lane_q.delete();
        model_q.delete();
    endtask

    task automatic reset_defaults();
        logic [31:0] rd;
        bus_read(reg_sr, rd);
        check_eq(rd, sr_word(1'b1, 1'b0, 1'b1), "SR after reset");
        bus_read(reg_cr, rd);
        check_eq(rd, 32'd0, "CR after reset");
        check_eq(lane_q.size(), 0, "lane quiet after reset");
    endtask

    task automatic pending_start();
        logic [31:0] rd;
        bus_write(reg_cr, 32'd1);
        bus_read(reg_cr, rd);
        check_eq(rd, 32'd1, "CR after load");
        bus_write(reg_cr_c, 32'd1);
        bus_read(reg_cr, rd);
        check_eq(rd, 32'd0, "CR after clear");
        bus_write(reg_cr_s, 32'd1);
        bus_read(reg_cr, rd);
        check_eq(rd, 32'd1, "CR after set, start pending");
        bus_write(reg_cr_c, 32'd1);
        bus_read(reg_cr, rd);
        check_eq(rd, 32'd0, "CR cleared again");
        check_eq(lane_q.size(), 0, "lane quiet with empty FIFO");
    endtask

    task automatic short_burst();
        logic [31:0] rd;
        push_symbol(symbol_t'{charisk: 1'b1, data: 8'hBC});  // comma character
        push_symbol(symbol_t'{charisk: 1'b0, data: 8'h50});
        push_symbol(symbol_t'{charisk: 1'b0, data: 8'hA5});
        push_symbol(symbol_t'{charisk: 1'b1, data: 8'h3C});
        push_symbol(symbol_t'{charisk: 1'b0, data: 8'hFF});
        bus_write(reg_cr_s, 32'd1);
        expect_lane("short burst");
        bus_read(reg_cr, rd);
        check_eq(rd, 32'd0, "start bit cleared itself");
    endtask

    task automatic full_fifo_drop();
        logic [31:0] rd;
        for (int i = 0; i < `TX_FIFO_DEPTH; i++) begin
            push_symbol(symbol_t'{charisk: i[0], data: 8'(8'h10 + i)});
        end
        bus_read(reg_sr, rd);
        check_eq(rd, sr_word(1'b1, 1'b1, 1'b0), "SR with FIFO full");
        bus_write(reg_data, 32'h0EE);  // dropped and left out of the model
        bus_read(reg_sr, rd);
        check_eq(rd, sr_word(1'b1, 1'b1, 1'b0), "SR after write to full FIFO");
        bus_write(reg_cr_s, 32'd1);
        expect_lane("full FIFO");
    endtask

    task automatic unmapped_access();
        logic [31:0] rd;
        bus_write(reg_cr, 32'd1);  // pending start makes CR nonzero
        bus_read(reg_data, rd);
        check_eq(rd, 32'd0, "DATA read");
        bus_read(reg_cr_s, rd);
        check_eq(rd, 32'd0, "CR_S read");
        bus_read(reg_cr_c, rd);
        check_eq(rd, 32'd0, "CR_C read");
        bus_read(8'h40, rd);
        check_eq(rd, 32'd0, "unmapped read");
        bus_write(reg_cr_c, 32'd1);
        bus_write(8'h20, 32'h1FF);
        bus_read(reg_sr, rd);
        check_eq(rd, sr_word(1'b1, 1'b0, 1'b1), "SR after unmapped write");
        bus_read(reg_cr, rd);
        check_eq(rd, 32'd0, "CR after unmapped write");
        check_eq(lane_q.size(), 0, "lane quiet after unmapped write");
    endtask

    task automatic random_bursts();
        int len;
        for (int b = 0; b < 3; b++) begin
            len = int'((lcg_next() >> 8) % 12) + 1;
            for (int i = 0; i < len; i++) begin
                push_symbol(random_symbol());
            end
            bus_write(reg_cr_s, 32'd1);
            expect_lane($sformatf("random burst %0d", b));
        end
    endtask

    initial begin
        lcg_state = lcg_seed;
        axi_req   = '0;
        tx_odd    = 1'b0;
        aresetn   = 1'b0;
        repeat (8) @(posedge app_clk);
        #1;
        aresetn = 1'b1;

        reset_defaults();
        pending_start();
        short_burst();
        full_fifo_drop();
        unmapped_access();
        random_bursts();

        $display("Regression passed");
        $finish;
    end

endmodule

//--- tx_buf_macros.svh
`ifndef TX_BUF_MACROS_SVH
`define TX_BUF_MACROS_SVH

// register bus geometry
`define MMR_ADDR_W 8      // byte address into the register page
`define MMR_DATA_W 32     // one bus word

// symbol storage
`define TX_FIFO_DEPTH 16  // queued symbols before writes are dropped

`endif

//--- tx_buf_pkg.sv
`include "tx_buf_macros.svh"

package tx_buf_pkg;

    // register page, byte addresses
    typedef enum logic [`MMR_ADDR_W-1:0] {
        reg_sr   = 'h00,  // status, read only
        reg_cr   = 'h04,  // control, load
        reg_cr_s = 'h08,  // control, set bits
        reg_cr_c = 'h0C,  // control, clear bits
        reg_data = 'h14   // symbol push, write only
    } tx_reg_e;

    typedef struct packed {
        logic ready;  // sequencer idle
        logic full;
        logic empty;
    } sr_t;

    typedef struct packed {
        logic start;  // one-shot, cleared once the lane is busy
    } cr_t;

    // one lane symbol
    typedef struct packed {
        logic       charisk;  // control character flag
        logic [7:0] data;
    } symbol_t;

    typedef struct packed {
        logic [`MMR_DATA_W-$bits(symbol_t)-1:0] pad;  // ignored on write
        symbol_t                                sym;
    } data_fields_t;

    // DATA register word, seen as bus word or as symbol
    typedef union packed {
        logic [`MMR_DATA_W-1:0] raw;
        data_fields_t           fields;
    } data_word_u;

endpackage

//--- tx_buffer.sv
module tx_buffer (
    input  logic                        app_clk,
    input  logic                        aresetn,
    input  axi_lite_pkg::axi_lite_req_t axi_req,
    output axi_lite_pkg::axi_lite_rsp_t axi_rsp,
    input  logic                        tx_odd,
    output logic [7:0]                  tx_data,
    output logic                        tx_charisk
);
    import tx_buf_pkg::*;

    symbol_t wr_sym;
    symbol_t rd_sym;
    logic    wr_en;
    logic    rd_en;
    logic    start;
    logic    idle;
    logic    full;
    logic    empty;

    mmr_regs u_regs (
        .app_clk (app_clk),
        .aresetn (aresetn),
        .axi_req (axi_req),
        .axi_rsp (axi_rsp),
        .idle    (idle),
        .full    (full),
        .empty   (empty),
        .start   (start),
        .wr_en   (wr_en),
        .wr_sym  (wr_sym)
    );

    sym_fifo u_fifo (
        .app_clk (app_clk),
        .aresetn (aresetn),
        .wr_en   (wr_en),
        .wr_sym  (wr_sym),
        .rd_en   (rd_en),
        .rd_sym  (rd_sym),
        .full    (full),
        .empty   (empty)
    );

    tx_ctrl u_ctrl (
        .app_clk    (app_clk),
        .aresetn    (aresetn),
        .start      (start),
        .tx_odd     (tx_odd),
        .empty      (empty),
        .rd_sym     (rd_sym),
        .rd_en      (rd_en),
        .idle       (idle),
        .tx_data    (tx_data),
        .tx_charisk (tx_charisk)
    );

endmodule

//--- tx_ctrl.sv
module tx_ctrl (
    input  logic                app_clk,
    input  logic                aresetn,
    input  logic                start,
    input  logic                tx_odd,
    input  logic                empty,
    input  tx_buf_pkg::symbol_t rd_sym,
    output logic                rd_en,
    output logic                idle,
    output logic [7:0]          tx_data,
    output logic                tx_charisk
);
    typedef enum logic [1:0] {
        st_idle,
        st_even,  // fetch slot
        st_odd    // symbol on the lane
    } state_e;

    state_e state;
    state_e state_nxt;

    always_ff @(posedge app_clk) begin
        if (!aresetn) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (start && tx_odd && !empty) begin
                    state_nxt = st_even;  // align burst to lane phase
                end
            end
            st_even: state_nxt = st_odd;
            st_odd:  state_nxt = empty ? st_idle : st_even;
            default: state_nxt = st_idle;
        endcase
    end

    assign rd_en      = state == st_even;
    assign idle       = state == st_idle;
    assign tx_data    = (state == st_odd) ? rd_sym.data : 8'h00;
    assign tx_charisk = (state == st_odd) && rd_sym.charisk;

    // lane carries a symbol only in the slot right after a FIFO read
    a_lane_after_read: assert property (@(posedge app_clk) disable iff (!aresetn)
        (tx_data != 8'h00 || tx_charisk) |-> $past(rd_en));

endmodule
